/* ooo_commit.f */
common/ooo_pkg.sv
verilog/stage_pipe.sv
verilog/dispatch_unit.sv
verilog/alu_unit.sv
verilog/load_unit.sv
verilog/arch_reg_file.sv
completion_buffer/completion_buffer.sv
verilog/ooo_commit.sv
verif/ooo_commit_checker.sv
verif/ooo_commit_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP       = ooo_commit_tb
FILELIST  = ooo_commit.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verif/ooo_commit_tb.sv */
// ----------------------------------------
// Testbench for the completion back end
// Seeded random traffic, in-order model,
// directed exceptions, load burst, watchdog
// ----------------------------------------
`timescale 1ns/1ns

module ooo_commit_tb;

  localparam int CB_DEPTH  = 8;
  localparam int ALU_LAT   = 2;
  localparam int LSU_LAT   = 10;
  localparam int MEM_WORDS = 16;
  localparam int MW_W      = $clog2(MEM_WORDS);
  localparam int N_RANDOM  = 300;
  localparam int N_BURST   = 24;
  localparam int N_TOTAL   = N_RANDOM + N_BURST + 6;
  localparam int WATCHDOG_NS = N_TOTAL * (LSU_LAT + CB_DEPTH) * 4 + 1000;

  typedef struct packed {
    ooo_pkg::word_t pc;
    ooo_pkg::word_t data;
    logic [4:0]     rd;
    ooo_pkg::exc_t  cause;
  } commit_exp_t;

  logic            CLK;
  logic            nRST;
  logic            instr_valid;
  ooo_pkg::op_t    instr_op;
  logic [4:0]      instr_rd;
  ooo_pkg::word_t  instr_a;
  ooo_pkg::word_t  instr_b;
  ooo_pkg::word_t  instr_pc;
  logic            mem_we;
  logic [MW_W-1:0] mem_addr;
  ooo_pkg::word_t  mem_wdata;
  logic [4:0]      rf_raddr;
  ooo_pkg::word_t  rf_rdata;
  logic            full;
  logic            empty;
  logic            commit_valid;
  logic [4:0]      commit_rd;
  ooo_pkg::word_t  commit_data;
  logic            commit_wen;
  logic            exc_valid;
  ooo_pkg::exc_t   exc_cause;
  ooo_pkg::word_t  exc_pc;

  commit_exp_t     exp_q [$];
  ooo_pkg::word_t  mem_img [MEM_WORDS];
  ooo_pkg::word_t  reg_img [32];
  ooo_pkg::word_t  pc;
  integer          seed;
  int              errors;
  int              n_commit;
  int              n_exc;
  int              n_illegal;
  int              n_misaligned;
  int              n_full;
  int              since_exc;
  int              full_mark;
  int              commit_mark;

  ooo_commit #(
    .CB_DEPTH  (CB_DEPTH),
    .ALU_LAT   (ALU_LAT),
    .LSU_LAT   (LSU_LAT),
    .MEM_WORDS (MEM_WORDS)
  ) i_ooo_commit (
    .CLK          (CLK),
    .nRST         (nRST),
    .instr_valid  (instr_valid),
    .instr_op     (instr_op),
    .instr_rd     (instr_rd),
    .instr_a      (instr_a),
    .instr_b      (instr_b),
    .instr_pc     (instr_pc),
    .mem_we       (mem_we),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .rf_raddr     (rf_raddr),
    .rf_rdata     (rf_rdata),
    .full         (full),
    .empty        (empty),
    .commit_valid (commit_valid),
    .commit_rd    (commit_rd),
    .commit_data  (commit_data),
    .commit_wen   (commit_wen),
    .exc_valid    (exc_valid),
    .exc_cause    (exc_cause),
    .exc_pc       (exc_pc)
  );

  bind completion_buffer ooo_commit_checker #(.CB_DEPTH(CB_DEPTH)) i_buffer_checker (
    .CLK          (CLK),
    .nRST         (nRST),
    .alloc        (alloc),
    .full         (full),
    .empty        (empty),
    .commit_valid (commit_valid),
    .exc_valid    (exc_valid)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

  // Expected commit or exception of one instruction
  function automatic commit_exp_t predict_commit(input logic [3:0] op, input logic [4:0] rd,
                                                 input ooo_pkg::word_t a,
                                                 input ooo_pkg::word_t b);
    commit_exp_t    e;
    ooo_pkg::word_t addr;
    ooo_pkg::word_t widx;
    addr    = a + b;
    widx    = (addr >> 2) % MEM_WORDS;
    e.pc    = pc;
    e.rd    = rd;
    e.data  = '0;
    e.cause = ooo_pkg::EXC_NONE;
    case (op)
      ooo_pkg::OP_ADD: e.data = a + b;
      ooo_pkg::OP_SUB: e.data = a - b;
      ooo_pkg::OP_XOR: e.data = a ^ b;
      ooo_pkg::OP_SLL: e.data = a << b[4:0];
      ooo_pkg::OP_LW: begin
        if (addr[1:0] != 2'b00) begin
          e.cause = ooo_pkg::EXC_MISALIGNED;
        end else begin
          e.data = mem_img[widx[MW_W-1:0]];
        end
      end
      default: e.cause = ooo_pkg::EXC_ILLEGAL;
    endcase
    return e;
  endfunction

  task automatic preload_ram();
    for (int i = 0; i < MEM_WORDS; i++) begin
      @(negedge CLK);
      mem_img[i[MW_W-1:0]] = (i * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
      mem_we    = 1'b1;
      mem_addr  = i[MW_W-1:0];
      mem_wdata = mem_img[i[MW_W-1:0]];
    end
    @(negedge CLK);
    mem_we = 1'b0;
  endtask

  // Waits out full, then offers one instruction
  task automatic offer_instr(input logic [3:0] op, input logic [4:0] rd,
                             input ooo_pkg::word_t a, input ooo_pkg::word_t b);
    @(negedge CLK);
    while (full) begin
      instr_valid = 1'b0;
      @(negedge CLK);
    end
    instr_valid = 1'b1;
    instr_op    = ooo_pkg::op_t'(op);
    instr_rd    = rd;
    instr_a     = a;
    instr_b     = b;
    instr_pc    = pc;
    // Offered during a flush, so the DUT discards it
    if (!exc_valid) begin
      exp_q.push_back(predict_commit(op, rd, a, b));
    end
    pc = pc + 32'd4;
  endtask

  task automatic idle_cycle();
    @(negedge CLK);
    instr_valid = 1'b0;
  endtask

  task automatic drain_buffer();
    idle_cycle();
    while (!empty) begin
      @(negedge CLK);
    end
  endtask

  task automatic random_instr(input bit burst);
    int             kind;
    ooo_pkg::word_t r1;
    ooo_pkg::word_t r2;
    ooo_pkg::word_t r3;
    kind = $unsigned($random(seed)) % 64;
    r1   = $random(seed);
    r2   = $random(seed);
    r3   = $random(seed);
    if (burst || (kind >= 32 && kind < 62)) begin
      offer_instr(ooo_pkg::OP_LW, r3[4:0], r1 & 32'hffff_fffc, {26'd0, r2[5:2], 2'b00});
    end else if (kind == 62) begin
      offer_instr(ooo_pkg::OP_LW, r3[4:0], r1 & 32'hffff_fffc,
                  {26'd0, r2[5:2], (r2[1:0] == 2'b00) ? 2'b11 : r2[1:0]});
    end else if (kind == 63) begin
      offer_instr(4'd5 + r2[3:0] % 4'd11, r3[4:0], r1, r2);
    end else begin
      offer_instr({2'b00, kind[1:0]}, r3[4:0], r1, r2);
    end
  endtask

  // Compares head events with the model queue
  always @(negedge CLK) begin
    commit_exp_t e;
    if (nRST) begin
      if (full) begin
        n_full++;
      end
      if (commit_valid) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Commit at %0t ns with no instruction outstanding", $time);
        end else begin
          e = exp_q.pop_front();
          if (e.cause != ooo_pkg::EXC_NONE || commit_rd != e.rd || commit_data != e.data ||
              !commit_wen) begin
            errors++;
            $display("Error at %0t ns: commit rd %0d data %h wen %b, expected rd %0d data %h",
                     $time, commit_rd, commit_data, commit_wen, e.rd, e.data);
          end
          if (e.rd != 5'd0) begin
            reg_img[e.rd] = e.data;
          end
          n_commit++;
          since_exc++;
        end
      end
      if (exc_valid) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Exception at %0t ns with no instruction outstanding", $time);
        end else begin
          e = exp_q[0];
          if (exc_cause != e.cause || exc_pc != e.pc) begin
            errors++;
            $display("Error at %0t ns: exception cause %0d pc %h, expected cause %0d pc %h",
                     $time, exc_cause, exc_pc, e.cause, e.pc);
          end
          if (e.cause == ooo_pkg::EXC_ILLEGAL) begin
            n_illegal++;
          end
          if (e.cause == ooo_pkg::EXC_MISALIGNED) begin
            n_misaligned++;
          end
          // Younger instructions are flushed with it
          exp_q.delete();
          n_exc++;
          since_exc = 0;
        end
      end
    end
  end

  initial begin
    seed         = 32'he484;
    errors       = 0;
    n_commit     = 0;
    n_exc        = 0;
    n_illegal    = 0;
    n_misaligned = 0;
    n_full       = 0;
    since_exc    = 0;
    pc           = 32'h0000_1000;
    nRST         = 1'b0;
    instr_valid  = 1'b0;
    instr_op     = ooo_pkg::OP_ADD;
    instr_rd     = 5'd0;
    instr_a      = '0;
    instr_b      = '0;
    instr_pc     = '0;
    mem_we       = 1'b0;
    mem_addr     = '0;
    mem_wdata    = '0;
    rf_raddr     = 5'd0;
    for (int r = 0; r < 32; r++) begin
      reg_img[r[4:0]] = '0;
    end

    repeat (2) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    if (!empty || full || commit_valid || exc_valid) begin
      errors++;
      $display("Error at %0t ns: outputs not idle after reset", $time);
    end
    preload_ram();

    // Mixed traffic with occasional faults
    for (int n = 0; n < N_RANDOM; n++) begin
      if ($unsigned($random(seed)) % 4 == 0) begin
        idle_cycle();
      end else begin
        random_instr(1'b0);
      end
    end
    drain_buffer();

    // Directed faults, each followed by a younger instruction
    offer_instr(ooo_pkg::OP_ADD, 5'd0, 32'd5, 32'd7);
    offer_instr(4'd9, 5'd3, 32'd1, 32'd1);
    offer_instr(ooo_pkg::OP_ADD, 5'd4, 32'd1, 32'd2);
    drain_buffer();
    offer_instr(ooo_pkg::OP_LW, 5'd6, 32'h10, 32'h2);
    offer_instr(ooo_pkg::OP_SUB, 5'd7, 32'd9, 32'd3);
    drain_buffer();

    // Back-to-back loads outlast the buffer depth
    full_mark   = n_full;
    commit_mark = n_commit;
    for (int n = 0; n < N_BURST; n++) begin
      random_instr(1'b1);
    end
    drain_buffer();
    if (n_full == full_mark) begin
      errors++;
      $display("Buffer never reported full during the load burst");
    end
    if (n_commit - commit_mark != N_BURST) begin
      errors++;
      $display("Error at %0t ns: %0d commits in the load burst, expected %0d",
               $time, n_commit - commit_mark, N_BURST);
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("Expected commits still outstanding after the buffer drained");
    end
    if (n_illegal == 0 || n_misaligned == 0) begin
      errors++;
      $display("An exception cause was never reported");
    end
    if (since_exc == 0) begin
      errors++;
      $display("No commit followed the last exception");
    end

    // Architectural register image
    for (int r = 0; r < 32; r++) begin
      @(negedge CLK);
      rf_raddr = r[4:0];
      @(posedge CLK);
      if (rf_rdata != reg_img[r[4:0]]) begin
        errors++;
        $display("Error at %0t ns: x%0d reads %h, expected %h",
                 $time, r, rf_rdata, reg_img[r[4:0]]);
      end
    end

    $display("Done: %0d commits, %0d exceptions, %0d full cycles, %0d errors",
             n_commit, n_exc, n_full, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* verif/ooo_commit_checker.sv */
// ----------------------------------------
// Assertions on the completion buffer
// Occupancy levels, and a single-cycle
// exception that leaves the buffer empty
// ----------------------------------------
`timescale 1ns/1ns

module ooo_commit_checker #(
  parameter int CB_DEPTH = 8
) (
  input logic CLK,
  input logic nRST,
  input logic alloc,
  input logic full,
  input logic empty,
  input logic commit_valid,
  input logic exc_valid
);

  // Entries allocated and not yet retired
  int occupancy;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      occupancy <= 0;
    end else if (exc_valid) begin
      occupancy <= 0;
    end else begin
      occupancy <= occupancy + (alloc ? 1 : 0) - (commit_valid ? 1 : 0);
    end
  end

  full_level: assert property (@(posedge CLK) disable iff (!nRST)
                               full == (occupancy == CB_DEPTH))
    else $error("full does not match the buffer occupancy");

  empty_level: assert property (@(posedge CLK) disable iff (!nRST)
                                empty == (occupancy == 0))
    else $error("empty does not match the buffer occupancy");

  // Stale done bits would retire right after the flush
  flush_single: assert property (@(posedge CLK) disable iff (!nRST)
                                 exc_valid |=> !exc_valid && !commit_valid)
    else $error("commit or exception in the cycle after an exception");

  flush_leaves_empty: assert property (@(posedge CLK) disable iff (!nRST) exc_valid |=> empty)
    else $error("buffer not empty one cycle after an exception");

endmodule

/* verilog/ooo_commit.sv */
// ---------------------------------------
// Out-of-order completion back end, top
// Dispatch, ALU, loads, buffer, reg file
// ---------------------------------------
`timescale 1ns/1ns

module ooo_commit #(
  parameter int CB_DEPTH  = 8,
  parameter int ALU_LAT   = 1,
  parameter int LSU_LAT   = 3,
  parameter int MEM_WORDS = 16
) (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          instr_valid,
  input  ooo_pkg::op_t                  instr_op,
  input  logic [4:0]                    instr_rd,
  input  ooo_pkg::word_t                instr_a,
  input  ooo_pkg::word_t                instr_b,
  input  ooo_pkg::word_t                instr_pc,
  input  logic                          mem_we,
  input  logic [$clog2(MEM_WORDS)-1:0]  mem_addr,
  input  ooo_pkg::word_t                mem_wdata,
  input  logic [4:0]                    rf_raddr,
  output ooo_pkg::word_t                rf_rdata,
  output logic                          full,
  output logic                          empty,
  output logic                          commit_valid,
  output logic [4:0]                    commit_rd,
  output ooo_pkg::word_t                commit_data,
  output logic                          commit_wen,
  output logic                          exc_valid,
  output ooo_pkg::exc_t                 exc_cause,
  output ooo_pkg::word_t                exc_pc
);

  localparam int IDX_W = $clog2(CB_DEPTH);

  logic             alloc;
  ooo_pkg::word_t   alloc_pc;
  logic [IDX_W-1:0] tail_index;
  logic             flush;

  logic             alu_valid;
  logic             load_valid;
  ooo_pkg::op_t     req_op;
  logic [4:0]       req_rd;
  ooo_pkg::word_t   req_a;
  ooo_pkg::word_t   req_b;
  logic [IDX_W-1:0] req_index;

  logic             alu_res_valid;
  logic [IDX_W-1:0] alu_res_index;
  ooo_pkg::word_t   alu_res_data;
  logic [4:0]       alu_res_rd;
  logic             alu_res_wen;
  ooo_pkg::exc_t    alu_res_cause;

  logic             ld_res_valid;
  logic [IDX_W-1:0] ld_res_index;
  ooo_pkg::word_t   ld_res_data;
  logic [4:0]       ld_res_rd;
  logic             ld_res_wen;
  ooo_pkg::exc_t    ld_res_cause;

  dispatch_unit #(.CB_DEPTH(CB_DEPTH)) i_dispatch_unit (
    .instr_valid (instr_valid),
    .instr_op    (instr_op),
    .instr_rd    (instr_rd),
    .instr_a     (instr_a),
    .instr_b     (instr_b),
    .instr_pc    (instr_pc),
    .full        (full),
    .flush       (flush),
    .tail_index  (tail_index),
    .alloc       (alloc),
    .alloc_pc    (alloc_pc),
    .alu_valid   (alu_valid),
    .load_valid  (load_valid),
    .req_op      (req_op),
    .req_rd      (req_rd),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_index   (req_index)
  );

  alu_unit #(.CB_DEPTH(CB_DEPTH), .ALU_LAT(ALU_LAT)) i_alu_unit (
    .CLK       (CLK),
    .nRST      (nRST),
    .flush     (flush),
    .alu_valid (alu_valid),
    .req_op    (req_op),
    .req_rd    (req_rd),
    .req_a     (req_a),
    .req_b     (req_b),
    .req_index (req_index),
    .res_valid (alu_res_valid),
    .res_index (alu_res_index),
    .res_data  (alu_res_data),
    .res_rd    (alu_res_rd),
    .res_wen   (alu_res_wen),
    .res_cause (alu_res_cause)
  );

  load_unit #(
    .CB_DEPTH  (CB_DEPTH),
    .LSU_LAT   (LSU_LAT),
    .MEM_WORDS (MEM_WORDS)
  ) i_load_unit (
    .CLK        (CLK),
    .nRST       (nRST),
    .flush      (flush),
    .load_valid (load_valid),
    .req_a      (req_a),
    .req_b      (req_b),
    .req_rd     (req_rd),
    .req_index  (req_index),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .res_valid  (ld_res_valid),
    .res_index  (ld_res_index),
    .res_data   (ld_res_data),
    .res_rd     (ld_res_rd),
    .res_wen    (ld_res_wen),
    .res_cause  (ld_res_cause)
  );

  completion_buffer #(.CB_DEPTH(CB_DEPTH)) i_completion_buffer (
    .CLK           (CLK),
    .nRST          (nRST),
    .alloc         (alloc),
    .alloc_pc      (alloc_pc),
    .alu_res_valid (alu_res_valid),
    .alu_res_index (alu_res_index),
    .alu_res_data  (alu_res_data),
    .alu_res_rd    (alu_res_rd),
    .alu_res_wen   (alu_res_wen),
    .alu_res_cause (alu_res_cause),
    .ld_res_valid  (ld_res_valid),
    .ld_res_index  (ld_res_index),
    .ld_res_data   (ld_res_data),
    .ld_res_rd     (ld_res_rd),
    .ld_res_wen    (ld_res_wen),
    .ld_res_cause  (ld_res_cause),
    .tail_index    (tail_index),
    .full          (full),
    .empty         (empty),
    .flush         (flush),
    .commit_valid  (commit_valid),
    .commit_rd     (commit_rd),
    .commit_data   (commit_data),
    .commit_wen    (commit_wen),
    .exc_valid     (exc_valid),
    .exc_cause     (exc_cause),
    .exc_pc        (exc_pc)
  );

  arch_reg_file i_arch_reg_file (
    .CLK         (CLK),
    .nRST        (nRST),
    .commit_wen  (commit_wen),
    .commit_rd   (commit_rd),
    .commit_data (commit_data),
    .rf_raddr    (rf_raddr),
    .rf_rdata    (rf_rdata)
  );

endmodule

/* completion_buffer/completion_buffer.sv */
// ---------------------------------------
// Circular in-order completion buffer
// Allocation, result write-back from two
// units, head commit and exception flush
// ---------------------------------------
`timescale 1ns/1ns

module completion_buffer #(
  parameter int CB_DEPTH = 8
) (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         alloc,
  input  ooo_pkg::word_t               alloc_pc,
  input  logic                         alu_res_valid,
  input  logic [$clog2(CB_DEPTH)-1:0]  alu_res_index,
  input  ooo_pkg::word_t               alu_res_data,
  input  logic [4:0]                   alu_res_rd,
  input  logic                         alu_res_wen,
  input  ooo_pkg::exc_t                alu_res_cause,
  input  logic                         ld_res_valid,
  input  logic [$clog2(CB_DEPTH)-1:0]  ld_res_index,
  input  ooo_pkg::word_t               ld_res_data,
  input  logic [4:0]                   ld_res_rd,
  input  logic                         ld_res_wen,
  input  ooo_pkg::exc_t                ld_res_cause,
  output logic [$clog2(CB_DEPTH)-1:0]  tail_index,
  output logic                         full,
  output logic                         empty,
  output logic                         flush,
  output logic                         commit_valid,
  output logic [4:0]                   commit_rd,
  output ooo_pkg::word_t               commit_data,
  output logic                         commit_wen,
  output logic                         exc_valid,
  output ooo_pkg::exc_t                exc_cause,
  output ooo_pkg::word_t               exc_pc
);

  localparam int IDX_W = $clog2(CB_DEPTH);

  // Pointers carry one extra wrap bit
  logic [IDX_W:0]   head;
  logic [IDX_W:0]   tail;
  logic [IDX_W-1:0] head_sel;

  logic             done_q  [CB_DEPTH];
  ooo_pkg::exc_t    cause_q [CB_DEPTH];
  ooo_pkg::word_t   data_q  [CB_DEPTH];
  logic [4:0]       rd_q    [CB_DEPTH];
  logic             wen_q   [CB_DEPTH];
  ooo_pkg::word_t   pc_q    [CB_DEPTH];

  assign head_sel   = head[IDX_W-1:0];
  assign tail_index = tail[IDX_W-1:0];

  assign empty = (head == tail);
  assign full  = (head[IDX_W-1:0] == tail[IDX_W-1:0]) && (head[IDX_W] != tail[IDX_W]);

  // A finished head either retires or raises the exception
  assign flush        = done_q[head_sel] && (cause_q[head_sel] != ooo_pkg::EXC_NONE);
  assign commit_valid = done_q[head_sel] && (cause_q[head_sel] == ooo_pkg::EXC_NONE);
  assign commit_rd    = rd_q[head_sel];
  assign commit_data  = data_q[head_sel];
  assign commit_wen   = commit_valid && wen_q[head_sel];

  assign exc_valid = flush;
  assign exc_cause = cause_q[head_sel];
  assign exc_pc    = pc_q[head_sel];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      head <= '0;
      tail <= '0;
    end else if (flush) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (commit_valid) begin
        head <= head + 1'b1;
      end
      if (alloc) begin
        tail <= tail + 1'b1;
      end
    end
  end

  // Entry status, cleared on commit and on flush
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < CB_DEPTH; i++) begin
        done_q[i]  <= 1'b0;
        cause_q[i] <= ooo_pkg::EXC_NONE;
      end
    end else if (flush) begin
      for (int i = 0; i < CB_DEPTH; i++) begin
        done_q[i]  <= 1'b0;
        cause_q[i] <= ooo_pkg::EXC_NONE;
      end
    end else begin
      if (commit_valid) begin
        done_q[head_sel] <= 1'b0;
      end
      if (alu_res_valid) begin
        done_q[alu_res_index]  <= 1'b1;
        cause_q[alu_res_index] <= alu_res_cause;
      end
      if (ld_res_valid) begin
        done_q[ld_res_index]  <= 1'b1;
        cause_q[ld_res_index] <= ld_res_cause;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (alloc) begin
      pc_q[tail_index] <= alloc_pc;
    end
    if (alu_res_valid) begin
      data_q[alu_res_index] <= alu_res_data;
      rd_q[alu_res_index]   <= alu_res_rd;
      wen_q[alu_res_index]  <= alu_res_wen;
    end
    if (ld_res_valid) begin
      data_q[ld_res_index] <= ld_res_data;
      rd_q[ld_res_index]   <= ld_res_rd;
      wen_q[ld_res_index]  <= ld_res_wen;
    end
  end

endmodule

/* verilog/arch_reg_file.sv */
// ---------------------------------------
// Architectural register file, x0 reads 0
// ---------------------------------------
`timescale 1ns/1ns

module arch_reg_file (
  input  logic            CLK,
  input  logic            nRST,
  input  logic            commit_wen,
  input  logic [4:0]      commit_rd,
  input  ooo_pkg::word_t  commit_data,
  input  logic [4:0]      rf_raddr,
  output ooo_pkg::word_t  rf_rdata
);

  ooo_pkg::word_t regs [32];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (commit_wen && (commit_rd != 5'd0)) begin
      regs[commit_rd] <= commit_data;
    end
  end

  assign rf_rdata = (rf_raddr == 5'd0) ? '0 : regs[rf_raddr];

endmodule

/* verilog/load_unit.sv */
// ---------------------------------------
// Load unit with word-addressed data RAM,
// preload port and misalignment check
// ---------------------------------------
`timescale 1ns/1ns

module load_unit #(
  parameter int CB_DEPTH  = 8,
  parameter int LSU_LAT   = 3,
  parameter int MEM_WORDS = 16
) (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          flush,
  input  logic                          load_valid,
  input  ooo_pkg::word_t                req_a,
  input  ooo_pkg::word_t                req_b,
  input  logic [4:0]                    req_rd,
  input  logic [$clog2(CB_DEPTH)-1:0]   req_index,
  input  logic                          mem_we,
  input  logic [$clog2(MEM_WORDS)-1:0]  mem_addr,
  input  ooo_pkg::word_t                mem_wdata,
  output logic                          res_valid,
  output logic [$clog2(CB_DEPTH)-1:0]   res_index,
  output ooo_pkg::word_t                res_data,
  output logic [4:0]                    res_rd,
  output logic                          res_wen,
  output ooo_pkg::exc_t                 res_cause
);

  ooo_pkg::load_req_t          req_in;
  ooo_pkg::load_req_t          req_out;
  logic                        pipe_valid;
  logic [$clog2(CB_DEPTH)-1:0] pipe_index;
  ooo_pkg::word_t              word_idx;
  ooo_pkg::word_t              mem [MEM_WORDS];

  assign req_in.addr = req_a + req_b;
  assign req_in.rd   = req_rd;

  // The RAM read adds the last cycle of latency
  stage_pipe #(
    .payload_t (ooo_pkg::load_req_t),
    .DEPTH     (LSU_LAT - 1),
    .CB_DEPTH  (CB_DEPTH)
  ) i_load_pipe (
    .CLK         (CLK),
    .nRST        (nRST),
    .flush       (flush),
    .in_valid    (load_valid),
    .in_index    (req_index),
    .in_payload  (req_in),
    .out_valid   (pipe_valid),
    .out_index   (pipe_index),
    .out_payload (req_out)
  );

  assign word_idx = (req_out.addr >> 2) % MEM_WORDS;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= pipe_valid && !flush;
    end
  end

  always_ff @(posedge CLK) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
    res_data  <= mem[word_idx[$clog2(MEM_WORDS)-1:0]];
    res_index <= pipe_index;
    res_rd    <= req_out.rd;
    res_cause <= (req_out.addr[1:0] != 2'b00) ? ooo_pkg::EXC_MISALIGNED : ooo_pkg::EXC_NONE;
  end

  assign res_wen = (res_cause == ooo_pkg::EXC_NONE);

endmodule

/* verilog/alu_unit.sv */
// ---------------------------------------
// Arithmetic unit, add/sub/xor/shift with
// illegal opcode detection
// ---------------------------------------
`timescale 1ns/1ns

module alu_unit #(
  parameter int CB_DEPTH = 8,
  parameter int ALU_LAT  = 1
) (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         flush,
  input  logic                         alu_valid,
  input  ooo_pkg::op_t                 req_op,
  input  logic [4:0]                   req_rd,
  input  ooo_pkg::word_t               req_a,
  input  ooo_pkg::word_t               req_b,
  input  logic [$clog2(CB_DEPTH)-1:0]  req_index,
  output logic                         res_valid,
  output logic [$clog2(CB_DEPTH)-1:0]  res_index,
  output ooo_pkg::word_t               res_data,
  output logic [4:0]                   res_rd,
  output logic                         res_wen,
  output ooo_pkg::exc_t                res_cause
);

  ooo_pkg::alu_res_t res_in;
  ooo_pkg::alu_res_t res_out;

  always_comb begin
    res_in.rd    = req_rd;
    res_in.wen   = 1'b1;
    res_in.cause = ooo_pkg::EXC_NONE;
    case (req_op)
      ooo_pkg::OP_ADD: res_in.data = req_a + req_b;
      ooo_pkg::OP_SUB: res_in.data = req_a - req_b;
      ooo_pkg::OP_XOR: res_in.data = req_a ^ req_b;
      ooo_pkg::OP_SLL: res_in.data = req_a << req_b[4:0];
      default: begin
        // No write back for an undefined opcode
        res_in.data  = '0;
        res_in.wen   = 1'b0;
        res_in.cause = ooo_pkg::EXC_ILLEGAL;
      end
    endcase
  end

  stage_pipe #(
    .payload_t (ooo_pkg::alu_res_t),
    .DEPTH     (ALU_LAT),
    .CB_DEPTH  (CB_DEPTH)
  ) i_alu_pipe (
    .CLK         (CLK),
    .nRST        (nRST),
    .flush       (flush),
    .in_valid    (alu_valid),
    .in_index    (req_index),
    .in_payload  (res_in),
    .out_valid   (res_valid),
    .out_index   (res_index),
    .out_payload (res_out)
  );

  assign res_data  = res_out.data;
  assign res_rd    = res_out.rd;
  assign res_wen   = res_out.wen;
  assign res_cause = res_out.cause;

endmodule

/* verilog/dispatch_unit.sv */
// ---------------------------------------
// Dispatch stage, allocates buffer entries
// and steers requests to the ALU or loads
// ---------------------------------------
`timescale 1ns/1ns

module dispatch_unit #(
  parameter int CB_DEPTH = 8
) (
  input  logic                         instr_valid,
  input  ooo_pkg::op_t                 instr_op,
  input  logic [4:0]                   instr_rd,
  input  ooo_pkg::word_t               instr_a,
  input  ooo_pkg::word_t               instr_b,
  input  ooo_pkg::word_t               instr_pc,
  input  logic                         full,
  input  logic                         flush,
  input  logic [$clog2(CB_DEPTH)-1:0]  tail_index,
  output logic                         alloc,
  output ooo_pkg::word_t               alloc_pc,
  output logic                         alu_valid,
  output logic                         load_valid,
  output ooo_pkg::op_t                 req_op,
  output logic [4:0]                   req_rd,
  output ooo_pkg::word_t               req_a,
  output ooo_pkg::word_t               req_b,
  output logic [$clog2(CB_DEPTH)-1:0]  req_index
);

  logic is_load;

  // Illegal codes go to the ALU, which raises the exception
  assign is_load = (instr_op == ooo_pkg::OP_LW);

  // Dropped when the buffer is full or flushing
  assign alloc    = instr_valid && !full && !flush;
  assign alloc_pc = instr_pc;

  assign alu_valid  = alloc && !is_load;
  assign load_valid = alloc && is_load;

  assign req_op    = instr_op;
  assign req_rd    = instr_rd;
  assign req_a     = instr_a;
  assign req_b     = instr_b;
  assign req_index = tail_index;

endmodule

/* verilog/stage_pipe.sv */
// ---------------------------------------
// Fixed-depth delay line for valid, index
// and a typed payload, with flush
// ---------------------------------------
`timescale 1ns/1ns

module stage_pipe #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 1,
  parameter int  CB_DEPTH  = 8
) (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         flush,
  input  logic                         in_valid,
  input  logic [$clog2(CB_DEPTH)-1:0]  in_index,
  input  payload_t                     in_payload,
  output logic                         out_valid,
  output logic [$clog2(CB_DEPTH)-1:0]  out_index,
  output payload_t                     out_payload
);

  logic                        valid_q   [DEPTH];
  logic [$clog2(CB_DEPTH)-1:0] index_q   [DEPTH];
  payload_t                    payload_q [DEPTH];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < DEPTH; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (flush) begin
      for (int i = 0; i < DEPTH; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else begin
      valid_q[0] <= in_valid;
      for (int i = 1; i < DEPTH; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  always_ff @(posedge CLK) begin
    index_q[0]   <= in_index;
    payload_q[0] <= in_payload;
    for (int i = 1; i < DEPTH; i++) begin
      index_q[i]   <= index_q[i-1];
      payload_q[i] <= payload_q[i-1];
    end
  end

  assign out_valid   = valid_q[DEPTH-1];
  assign out_index   = index_q[DEPTH-1];
  assign out_payload = payload_q[DEPTH-1];

endmodule

/* common/ooo_pkg.sv */
// ---------------------------------------
// Shared types for the completion back end
// Opcodes, exception causes, unit payloads
// ---------------------------------------

package ooo_pkg;

  typedef logic [31:0] word_t;

  // Codes 5 to 15 are illegal
  typedef enum logic [3:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_XOR = 4'd2,
    OP_SLL = 4'd3,
    OP_LW  = 4'd4
  } op_t;

  // Any nonzero cause at the head flushes the buffer
  typedef enum logic [1:0] {
    EXC_NONE       = 2'd0,
    EXC_ILLEGAL    = 2'd1,
    EXC_MISALIGNED = 2'd2
  } exc_t;

  typedef struct packed {
    word_t      data;
    logic [4:0] rd;
    logic       wen;
    exc_t       cause;
  } alu_res_t;

  typedef struct packed {
    word_t      addr;
    logic [4:0] rd;
  } load_req_t;

endpackage
